// File: logic/axi2ahb_pkg.sv
// Widths, channel structs and bus encodings shared by the AXI to AHB bridge.
// Every bridge module imports this package.
`default_nettype none

package axi2ahb_pkg;

  localparam int ADDR_W = 40;
  localparam int DATA_W = 128;
  localparam int ID_W   = 8;
  localparam int LEN_W  = 8;

  // one AXI address-channel request that serves both AW and AR.
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [1:0]        burst;
    logic [2:0]        size;
    logic [LEN_W-1:0]  len;
    logic [ID_W-1:0]   id;
    logic [2:0]        prot;
    logic [3:0]        cache;
  } axi_req_t;

  typedef struct packed {
    logic [ADDR_W-1:0] haddr;
    logic [2:0]        hburst;
    logic [2:0]        hsize;
    logic [3:0]        hprot;
    logic              hwrite;
    logic [1:0]        htrans;
  } ahb_ctrl_t;

  typedef enum logic [1:0] {RESP_OKAY = 2'b00, RESP_SLVERR = 2'b10} axi_resp_e;

  typedef enum logic [1:0] {HT_IDLE = 2'b00, HT_NONSEQ = 2'b10, HT_SEQ = 2'b11} htrans_e;

  typedef enum logic [2:0] {
    HB_INCR  = 3'b001,
    HB_WRAP4 = 3'b010,
    HB_INCR4 = 3'b011,
    HB_WRAP8 = 3'b100,
    HB_INCR8 = 3'b101
  } hburst_e;

  typedef enum logic [1:0] {AXB_INCR = 2'b01, AXB_WRAP = 2'b10} axi_burst_e;

  // one-hot transaction state.
  typedef enum logic [8:0] {
    ST_IDLE       = 9'b000000001,
    ST_WR_COLLECT = 9'b000000010,
    ST_WR_AHB     = 9'b000000100,
    ST_WR_LAST    = 9'b000001000,
    ST_WR_RESP    = 9'b000010000,
    ST_RD_AHB     = 9'b000100000,
    ST_RD_LAST    = 9'b001000000,
    ST_RD_AXI     = 9'b010000000,
    ST_RD_PRELOAD = 9'b100000000
  } bridge_state_e;

endpackage

`default_nettype wire

// File: logic/bridge_ctrl.sv
// Transaction FSM of the bridge with the beat counters and buffer strobes.
// Also drives the AXI handshakes and registers the write response.
`default_nettype none

module bridge_ctrl (
  input  logic                            pll_core_cpuclk,
  input  logic                            pad_cpu_rst_b,
  input  logic                            aw_valid,
  input  logic                            ar_valid,
  input  logic [axi2ahb_pkg::LEN_W-1:0]   aw_len,
  input  logic [axi2ahb_pkg::LEN_W-1:0]   ar_len,
  input  logic                            w_valid,
  input  logic                            w_last,
  input  logic                            b_ready,
  input  logic                            r_ready,
  input  logic                            hready,
  input  logic [1:0]                      hresp,
  input  logic                            buf_empty,
  output logic                            aw_ready,
  output logic                            ar_ready,
  output logic                            w_ready,
  output logic                            b_valid,
  output logic                            r_valid,
  output logic                            r_last,
  output logic                            req_take,
  output logic                            req_write,
  output logic                            seq_phase,
  output logic                            last_beat,
  output logic                            ahb_err,
  output logic                            buf_clr,
  output logic                            buf_wr,
  output logic                            buf_rd,
  output logic                            buf_err,
  output axi2ahb_pkg::axi_resp_e          b_resp
);
  import axi2ahb_pkg::*;

  bridge_state_e    state;
  bridge_state_e    state_nxt;
  logic [LEN_W-1:0] wr_cnt;
  logic [LEN_W-1:0] rd_cnt;
  logic             first_rd;   // the first read cycle carries an address phase only.
  logic             wr_zero;
  logic             rd_zero;

  assign wr_zero = (wr_cnt == '0);
  assign rd_zero = (rd_cnt == '0);
  assign ahb_err = hready && (|hresp);

  assign aw_ready  = (state == ST_IDLE) && aw_valid;
  assign ar_ready  = (state == ST_IDLE) && ar_valid && !aw_valid; // write wins a tie.
  assign req_take  = aw_ready || ar_ready;
  assign req_write = aw_valid;
  assign w_ready   = (state == ST_WR_COLLECT);
  assign b_valid   = (state == ST_WR_RESP);
  assign r_valid   = (state == ST_RD_AXI);
  assign r_last    = r_valid && buf_empty;
  assign last_beat = (state == ST_WR_AHB) ? wr_zero : rd_zero;
  // beats are issued whenever the FSM is about to sit in a burst state.
  assign seq_phase = (state_nxt == ST_WR_AHB) || (state_nxt == ST_RD_AHB);

  always_comb
  begin
    state_nxt = state;
    case (state)
      ST_IDLE:       if (aw_valid) state_nxt = ST_WR_COLLECT;
                     else if (ar_valid) state_nxt = ST_RD_AHB;
      ST_WR_COLLECT: if (w_valid && w_last) state_nxt = ST_WR_AHB;
      ST_WR_AHB:     if (ahb_err) state_nxt = ST_WR_RESP;
                     else if (wr_zero && hready) state_nxt = ST_WR_LAST;
      ST_WR_LAST:    if (hready) state_nxt = ST_WR_RESP;
      ST_WR_RESP:    if (b_ready) state_nxt = ST_IDLE;
      ST_RD_AHB:     if (rd_zero && hready) state_nxt = ST_RD_LAST;
      ST_RD_LAST:    if (hready) state_nxt = ST_RD_PRELOAD;
      ST_RD_PRELOAD: state_nxt = ST_RD_AXI;
      ST_RD_AXI:     if (buf_empty && r_ready) state_nxt = ST_IDLE;
      default:       state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge pll_core_cpuclk or negedge pad_cpu_rst_b)
  begin
    if (!pad_cpu_rst_b)
    begin
      state    <= ST_IDLE;
      wr_cnt   <= '0;
      rd_cnt   <= '0;
      first_rd <= 1'b0;
    end
    else
    begin
      state <= state_nxt;
      if (aw_ready)
        wr_cnt <= aw_len;
      else if ((state == ST_WR_AHB) && hready)
        wr_cnt <= wr_cnt - 1'b1;
      if (ar_ready)
        rd_cnt <= ar_len;
      else if ((state == ST_RD_AHB) && hready)
        rd_cnt <= rd_cnt - 1'b1;
      if (ar_ready)
        first_rd <= 1'b1;
      else if ((state == ST_RD_AHB) && hready)
        first_rd <= 1'b0;
    end
  end

  assign buf_clr = (state == ST_IDLE);
  assign buf_wr  = (w_ready && w_valid) ||
                   (((state == ST_RD_AHB) || (state == ST_RD_LAST)) && hready && !first_rd);
  assign buf_err = ahb_err && ((state == ST_RD_AHB) || (state == ST_RD_LAST));
  assign buf_rd  = ((state == ST_WR_AHB) && hready) || (r_valid && r_ready) ||
                   (state == ST_RD_PRELOAD);

  // the code follows each completed write data phase and holds until b_ready.
  always_ff @(posedge pll_core_cpuclk)
  begin
    if (((state == ST_WR_AHB) || (state == ST_WR_LAST)) && hready)
      b_resp <= ahb_err ? RESP_SLVERR : RESP_OKAY;
    else if (!(b_valid && !b_ready))
      b_resp <= RESP_OKAY;
  end

endmodule

`default_nettype wire

// File: logic/ahb_request.sv
// Captures the accepted AXI request and drives the AHB address phase.
// Steps the burst address with the wrap rule and keeps the response IDs.
`default_nettype none

module ahb_request (
  input  logic                            pll_core_cpuclk,
  input  logic                            pad_cpu_rst_b,
  input  axi2ahb_pkg::axi_req_t           aw_req,
  input  axi2ahb_pkg::axi_req_t           ar_req,
  input  logic                            req_take,
  input  logic                            req_write,
  input  logic                            seq_phase,
  input  logic                            last_beat,
  input  logic                            hready,
  input  logic                            ahb_err,
  output axi2ahb_pkg::ahb_ctrl_t          ahb_ctrl,
  output logic [axi2ahb_pkg::ID_W-1:0]    b_id,
  output logic [axi2ahb_pkg::ID_W-1:0]    r_id
);
  import axi2ahb_pkg::*;

  axi_req_t          req;
  hburst_e           hburst_sel;
  logic [ADDR_W-1:0] haddr_q;
  logic [ADDR_W-1:0] addr_nxt;
  hburst_e           hburst_q;
  logic [2:0]        hsize_q;
  logic [3:0]        hprot_q;
  logic              hwrite_q;
  htrans_e           htrans_q;
  logic [LEN_W-1:0]  len_q;
  logic              in_burst;
  logic              step;

  assign req = req_write ? aw_req : ar_req;

  always_comb
  begin
    hburst_sel = HB_INCR;   // length 1 and anything unsupported use undefined INCR.
    case (req.burst)
      AXB_INCR: if (req.len == 8'd3) hburst_sel = HB_INCR4;
                else if (req.len == 8'd7) hburst_sel = HB_INCR8;
      AXB_WRAP: if (req.len == 8'd3) hburst_sel = HB_WRAP4;
                else if (req.len == 8'd7) hburst_sel = HB_WRAP8;
      default:  hburst_sel = HB_INCR;
    endcase
  end

  always_ff @(posedge pll_core_cpuclk)
  begin
    if (req_take)
    begin
      hburst_q <= hburst_sel;
      hsize_q  <= req.size;
      hprot_q  <= {req.cache[1], 1'b0, req.prot[0], req.prot[2]};
      hwrite_q <= req_write;
      len_q    <= req.len;
    end
    if (req_take && req_write)
      b_id <= aw_req.id;
    if (req_take && !req_write)
      r_id <= ar_req.id;
  end

  // the beat index in bits 6:4 counts inside a window of 2, 4 or 8 words.
  always_comb
  begin
    addr_nxt = haddr_q;
    case (len_q)
      8'd1:    addr_nxt[4]   = ~haddr_q[4];
      8'd3:    addr_nxt[5:4] = haddr_q[5:4] + 2'd1;
      8'd7:    addr_nxt[6:4] = haddr_q[6:4] + 3'd1;
      default: addr_nxt      = haddr_q;
    endcase
  end

  // htrans is only non-idle while the FSM sits in a burst state.
  assign in_burst = (htrans_q != HT_IDLE);
  assign step     = in_burst && hready && !last_beat;

  always_ff @(posedge pll_core_cpuclk)
  begin
    if (req_take)
      haddr_q <= req.addr;
    else if (step)
      haddr_q <= addr_nxt;
  end

  always_ff @(posedge pll_core_cpuclk or negedge pad_cpu_rst_b)
  begin
    if (!pad_cpu_rst_b)
      htrans_q <= HT_IDLE;
    else if (seq_phase && !in_burst)
      htrans_q <= HT_NONSEQ;
    else if (hwrite_q && in_burst && ahb_err)
      htrans_q <= HT_IDLE;    // a failed write beat ends the burst early.
    else if (step)
      htrans_q <= HT_SEQ;
    else if (!(in_burst && !hready))
      htrans_q <= HT_IDLE;
  end

  assign ahb_ctrl = '{haddr:  haddr_q,
                      hburst: hburst_q,
                      hsize:  hsize_q,
                      hprot:  hprot_q,
                      hwrite: hwrite_q,
                      htrans: htrans_q};

endmodule

`default_nettype wire

// File: logic/data_buffer.sv
// Word buffer between the AXI and AHB sides, filled by one and drained by the other.
// The output register feeds both hwdata and the AXI read data.
`default_nettype none

module data_buffer #(
  parameter int BUF_DEPTH = 8
) (
  input  logic                              pll_core_cpuclk,
  input  logic                              pad_cpu_rst_b,
  input  logic                              clr,
  input  logic                              wr,
  input  logic                              rd,
  input  logic                              wr_err,
  input  logic                              hwrite,
  input  logic [axi2ahb_pkg::DATA_W-1:0]    w_data,
  input  logic [axi2ahb_pkg::DATA_W-1:0]    hrdata,
  output logic                              empty,
  output logic [axi2ahb_pkg::DATA_W-1:0]    out_data,
  output axi2ahb_pkg::axi_resp_e            out_resp
);
  import axi2ahb_pkg::*;

  localparam int IDX_W = $clog2(BUF_DEPTH);

  logic [DATA_W-1:0] mem [BUF_DEPTH];
  logic              err [BUF_DEPTH];
  logic [IDX_W:0]    wptr;   // one extra bit so a full buffer differs from an empty one.
  logic [IDX_W:0]    rptr;

  assign empty = (wptr == rptr);

  always_ff @(posedge pll_core_cpuclk or negedge pad_cpu_rst_b)
  begin
    if (!pad_cpu_rst_b)
    begin
      wptr <= '0;
      rptr <= '0;
    end
    else if (clr)
    begin
      wptr <= '0;
      rptr <= '0;
    end
    else
    begin
      if (wr)
        wptr <= wptr + 1'b1;
      if (rd)
        rptr <= rptr + 1'b1;
    end
  end

  always_ff @(posedge pll_core_cpuclk)
  begin
    if (wr)
    begin
      mem[wptr[IDX_W-1:0]] <= hwrite ? w_data : hrdata;
      err[wptr[IDX_W-1:0]] <= wr_err;
    end
    if (rd)
    begin
      out_data <= mem[rptr[IDX_W-1:0]];
      out_resp <= err[rptr[IDX_W-1:0]] ? RESP_SLVERR : RESP_OKAY;
    end
  end

endmodule

`default_nettype wire

// File: logic/axi2ahb.sv
// AXI to AHB burst bridge top level for one outstanding transaction.
// Connects the controller, the AHB request unit and the data buffer.
`default_nettype none

module axi2ahb #(
  parameter int BUF_DEPTH = 8
) (
  input  logic                               pll_core_cpuclk,
  input  logic                               pad_cpu_rst_b,
  input  axi2ahb_pkg::axi_req_t              aw_req,
  input  logic                               aw_valid,
  output logic                               aw_ready,
  input  logic [axi2ahb_pkg::DATA_W-1:0]     w_data,
  input  logic                               w_valid,
  input  logic                               w_last,
  output logic                               w_ready,
  output logic                               b_valid,
  output axi2ahb_pkg::axi_resp_e             b_resp,
  output logic [axi2ahb_pkg::ID_W-1:0]       b_id,
  input  logic                               b_ready,
  input  axi2ahb_pkg::axi_req_t              ar_req,
  input  logic                               ar_valid,
  output logic                               ar_ready,
  output logic                               r_valid,
  output logic [axi2ahb_pkg::DATA_W-1:0]     r_data,
  output axi2ahb_pkg::axi_resp_e             r_resp,
  output logic [axi2ahb_pkg::ID_W-1:0]       r_id,
  output logic                               r_last,
  input  logic                               r_ready,
  output axi2ahb_pkg::ahb_ctrl_t             ahb_ctrl,
  output logic [axi2ahb_pkg::DATA_W-1:0]     hwdata,
  input  logic [axi2ahb_pkg::DATA_W-1:0]     hrdata,
  input  logic                               hready,
  input  logic [1:0]                         hresp
);
  import axi2ahb_pkg::*;

  logic              req_take;
  logic              req_write;
  logic              seq_phase;
  logic              last_beat;
  logic              ahb_err;
  logic              buf_clr;
  logic              buf_wr;
  logic              buf_rd;
  logic              buf_err;
  logic              buf_empty;
  logic [DATA_W-1:0] buf_word;

  assign hwdata = buf_word; // one register serves both the AHB write and AXI read data.
  assign r_data = buf_word;

  bridge_ctrl u_ctrl (
    .pll_core_cpuclk, .pad_cpu_rst_b,
    .aw_valid, .ar_valid, .aw_len(aw_req.len), .ar_len(ar_req.len),
    .w_valid, .w_last, .b_ready, .r_ready, .hready, .hresp, .buf_empty,
    .aw_ready, .ar_ready, .w_ready, .b_valid, .r_valid, .r_last,
    .req_take, .req_write, .seq_phase, .last_beat, .ahb_err,
    .buf_clr, .buf_wr, .buf_rd, .buf_err, .b_resp
  );

  ahb_request u_req (
    .pll_core_cpuclk, .pad_cpu_rst_b,
    .aw_req, .ar_req, .req_take, .req_write, .seq_phase, .last_beat,
    .hready, .ahb_err, .ahb_ctrl, .b_id, .r_id
  );

  data_buffer #(.BUF_DEPTH(BUF_DEPTH)) u_buf (
    .pll_core_cpuclk, .pad_cpu_rst_b,
    .clr(buf_clr), .wr(buf_wr), .rd(buf_rd), .wr_err(buf_err),
    .hwrite(ahb_ctrl.hwrite), .w_data, .hrdata,
    .empty(buf_empty), .out_data(buf_word), .out_resp(r_resp)
  );

endmodule

`default_nettype wire

// File: test/tb_clock.sv
// Clock and reset source for the bridge testbench.
// Reset is held low for a fixed number of cycles, then released after a rising edge.
`default_nettype none

module tb_clock #(
  parameter int PERIOD     = 40,
  parameter int RST_CYCLES = 5
) (
  output logic pll_core_cpuclk,
  output logic pad_cpu_rst_b
);

  initial
  begin
    pll_core_cpuclk = 1'b0;
    forever #(PERIOD / 2) pll_core_cpuclk = ~pll_core_cpuclk;
  end

  initial
  begin
    pad_cpu_rst_b = 1'b0;
    repeat (RST_CYCLES) @(posedge pll_core_cpuclk);
    #2 pad_cpu_rst_b = 1'b1;   // released off the edge like every other input.
  end

endmodule

`default_nettype wire

// File: test/axi2ahb_tb.sv
// Testbench for the AXI to AHB bridge with an AXI master, an AHB slave memory model and
// reference functions for addresses, hburst and responses. Stops at the first error.
`default_nettype none

module axi2ahb_tb;
  import axi2ahb_pkg::*;

  localparam int N_PAIRS = 12;
  localparam int N_TRANS = 2 * N_PAIRS + 4;
  localparam int LIMIT   = 64 * N_TRANS + 10;

  logic pll_core_cpuclk, pad_cpu_rst_b;
  axi_req_t aw_req, ar_req;
  logic aw_valid, aw_ready, w_valid, w_last, w_ready, b_valid, b_ready;
  logic ar_valid, ar_ready, r_valid, r_last, r_ready, hready;
  logic [DATA_W-1:0] w_data, r_data, hwdata, hrdata;
  logic [ID_W-1:0] b_id, r_id;
  logic [1:0] hresp;
  axi_resp_e b_resp, r_resp;
  ahb_ctrl_t ahb_ctrl;

  logic [DATA_W-1:0] mem [64];   // slave memory with one entry per 16-byte word.
  logic [31:0] lfsr_state = 32'd32242;
  axi_req_t cur_req;
  logic cur_write, pend_valid, pend_write, err_wr_seen, wr_active, hold_ar;
  logic [ADDR_W-1:0] pend_addr;
  int pend_beat, addr_beat, err_beat, cycles;

  tb_clock #(.PERIOD(40), .RST_CYCLES(5)) u_clock (.pll_core_cpuclk, .pad_cpu_rst_b);

  axi2ahb #(.BUF_DEPTH(8)) DUT (.*);

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v[i] = lfsr_state[0];
      lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h80200003 : 32'h0);
    end
    return v;
  endfunction

  function automatic int mem_idx(input logic [ADDR_W-1:0] a);
    return int'(a[9:4]);
  endfunction

  // wrap bursts count the beat field inside the window while incr bursts simply add a word.
  function automatic logic [ADDR_W-1:0] ref_addr(input axi_req_t r, input int i);
    logic [2:0] mask;
    logic [2:0] field;
    mask  = r.len[2:0];
    field = (r.addr[6:4] & mask) + 3'(i);
    if (r.burst == AXB_INCR)
      return r.addr + ADDR_W'(i * 16);
    return {r.addr[ADDR_W-1:7], (r.addr[6:4] & ~mask) | (field & mask), r.addr[3:0]};
  endfunction

  function automatic hburst_e ref_hburst(input axi_req_t r);
    if (r.len == 8'd3)
      return (r.burst == AXB_WRAP) ? HB_WRAP4 : HB_INCR4;
    if (r.len == 8'd7)
      return (r.burst == AXB_WRAP) ? HB_WRAP8 : HB_INCR8;
    return HB_INCR;
  endfunction

  function automatic axi_resp_e ref_resp(input logic err);
    return err ? RESP_SLVERR : RESP_OKAY;
  endfunction

  function automatic ahb_ctrl_t exp_ctrl(input axi_req_t r, input logic wr, input int i);
    return '{haddr: ref_addr(r, i), hburst: ref_hburst(r), hsize: r.size,
             hprot: {r.cache[1], 1'b0, r.prot[0], r.prot[2]}, hwrite: wr,
             htrans: (i == 0) ? HT_NONSEQ : HT_SEQ};
  endfunction

  task automatic stop_on_error();
    $display("ERRORS FOUND");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_ctrl(input string name, input ahb_ctrl_t got, input ahb_ctrl_t exp);
    if (got !== exp)
    begin
      $display("MISMATCH %s got %h expected %h", name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_data(input string name, input logic [DATA_W-1:0] got,
                            input logic [DATA_W-1:0] exp);
    if (got !== exp)
    begin
      $display("MISMATCH %s got %h expected %h", name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_resp(input string name, input axi_resp_e got, input axi_resp_e exp);
    if (got !== exp)
    begin
      $display("MISMATCH %s got %h expected %h", name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_id(input string name, input logic [ID_W-1:0] got,
                          input logic [ID_W-1:0] exp);
    if (got !== exp)
    begin
      $display("MISMATCH %s got %h expected %h", name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("MISMATCH %s got %h expected %h", name, got, exp);
      stop_on_error();
    end
  endtask

  // the slave answers the pending data phase and errors on the chosen beat.
  task automatic ahb_drive();
    hready = (take_bits(2) != 0);
    hresp  = 2'b00;
    hrdata = '0;
    if (pend_valid && !pend_write)
      hrdata = mem[mem_idx(pend_addr)];
    if (pend_valid && hready && pend_beat == err_beat)
      hresp = 2'b01;
  endtask

  task automatic ahb_observe();
    if (err_wr_seen)
    begin
      err_wr_seen = 1'b0;
      if (ahb_ctrl.htrans != HT_IDLE)
      begin
        $display("htrans did not return to IDLE after the AHB write error");
        stop_on_error();
      end
    end
    if (hready)
    begin
      if (pend_valid && pend_write && hresp != 2'b00)
        err_wr_seen = 1'b1;   // the address phase of this cycle is cancelled.
      else if (pend_valid && pend_write)
        mem[mem_idx(pend_addr)] = hwdata;
      pend_valid = 1'b0;
      if (ahb_ctrl.htrans != HT_IDLE && !err_wr_seen)
      begin
        if (addr_beat > int'(cur_req.len))
        begin
          $display("AHB address phase issued after the end of the burst");
          stop_on_error();
        end
        check_ctrl("ahb_ctrl", ahb_ctrl, exp_ctrl(cur_req, cur_write, addr_beat));
        pend_valid = 1'b1;
        pend_addr  = ahb_ctrl.haddr;
        pend_write = ahb_ctrl.hwrite;
        pend_beat  = addr_beat;
        addr_beat++;
      end
    end
  endtask

  task automatic edge_drive();
    @(posedge pll_core_cpuclk);
    #2;
    ahb_drive();
    aw_valid = 1'b0;
    w_valid  = 1'b0;
    w_last   = 1'b0;
    b_ready  = 1'b0;
    r_ready  = 1'b0;
    ar_valid = hold_ar;
  endtask

  task automatic settle();
    #1;
    ahb_observe();
    check_flag("ar_ready", ar_ready && wr_active, 1'b0);   // a write holds off the read.
  endtask

  task automatic start_ahb(input axi_req_t r, input logic wr, input int err);
    cur_req   = r;
    cur_write = wr;
    addr_beat = 0;
    err_beat  = err;
  endtask

  task automatic make_req(output axi_req_t r);
    logic [31:0] hi;
    logic [31:0] lo;
    r       = '0;
    r.len   = (8'd1 << take_bits(2)) - 8'd1;
    r.burst = (take_bits(1) != 0) ? AXB_WRAP : AXB_INCR;
    hi      = take_bits(30);
    lo      = take_bits(6);
    r.addr  = {hi[29:0], lo[5:0], 4'h0};
    if (r.burst == AXB_INCR)
      r.addr[6:4] = r.addr[6:4] & ~r.len[2:0];
    r.size  = 3'd4;
    r.id    = ID_W'(take_bits(8));
    r.prot  = 3'(take_bits(3));
    r.cache = 4'(take_bits(4));
  endtask

  task automatic run_write(input axi_req_t req, input int err, input logic with_read,
                           input axi_req_t rd_req);
    logic [DATA_W-1:0] wdata [8];
    int j;
    logic done;
    for (int i = 0; i < 8; i++)
      wdata[i] = {take_bits(32), take_bits(32), take_bits(32), take_bits(32)};
    start_ahb(req, 1'b1, err);
    wr_active = 1'b1;
    hold_ar   = with_read;
    edge_drive();
    aw_req   = req;
    aw_valid = 1'b1;
    ar_req   = rd_req;
    settle();
    check_flag("aw_ready", aw_ready, 1'b1);
    j = 0;
    while (j <= int'(req.len))
    begin
      edge_drive();
      w_valid = (take_bits(2) != 0);
      w_data  = wdata[j];
      w_last  = (j == int'(req.len));
      settle();
      check_flag("w_ready", w_ready, 1'b1);
      if (w_valid && w_ready)
        j++;
    end
    done = 1'b0;
    while (!done)
    begin
      edge_drive();
      b_ready = (take_bits(1) != 0);
      settle();
      check_flag("w_ready", w_ready, 1'b0);
      if (b_valid)
      begin
        check_resp("b_resp", b_resp, ref_resp(err >= 0));
        check_id("b_id", b_id, req.id);
        done = b_ready;
      end
    end
    wr_active = 1'b0;
    if (err >= 0 && addr_beat > int'(req.len))
    begin
      $display("AHB write burst was not cut short by the error");
      stop_on_error();
    end
    for (int i = 0; i <= int'(req.len) && err < 0; i++)
      check_data("slave memory", mem[mem_idx(ref_addr(req, i))], wdata[i]);
  endtask

  task automatic run_read(input axi_req_t req, input int err);
    int beat;
    start_ahb(req, 1'b0, err);
    hold_ar = 1'b0;
    edge_drive();
    ar_req   = req;
    ar_valid = 1'b1;
    settle();
    while (!ar_ready)
    begin
      edge_drive();
      ar_valid = 1'b1;
      settle();
    end
    beat = 0;
    while (beat <= int'(req.len))
    begin
      edge_drive();
      r_ready = (take_bits(1) != 0);
      settle();
      if (r_valid)
      begin
        check_data("r_data", r_data, mem[mem_idx(ref_addr(req, beat))]);
        check_resp("r_resp", r_resp, ref_resp(beat == err));
        check_id("r_id", r_id, req.id);
        check_flag("r_last", r_last, beat == int'(req.len));
        if (r_ready)
          beat++;
      end
    end
  endtask

  always @(posedge pll_core_cpuclk)
  begin
    cycles++;
    if (cycles > LIMIT)
    begin
      $display("timeout after %0d cycles without finishing the tests", LIMIT);
      $display("ERRORS FOUND");
      $fatal(1, "timeout");
    end
  end

  initial
  begin
    axi_req_t req;
    axi_req_t req2;
    cycles = 0;
    aw_req = '0;
    ar_req = '0;
    {aw_valid, w_valid, w_last, b_ready, ar_valid, r_ready} = '0;
    w_data = '0;
    hready = 1'b1;
    hresp  = 2'b00;
    hrdata = '0;
    {pend_valid, pend_write, err_wr_seen, wr_active, hold_ar, cur_write} = '0;
    pend_addr = '0;
    pend_beat = 0;
    addr_beat = 0;
    err_beat  = -1;
    cur_req   = '0;
    for (int i = 0; i < 64; i++)
      mem[i] = {4{(32'(i) * 32'h9E3779B1) ^ 32'h5A5A0000}};
    wait (pad_cpu_rst_b === 1'b1);
    edge_drive();
    settle();
    check_flag("htrans_idle", ahb_ctrl.htrans == HT_IDLE, 1'b1);
    check_flag("b_valid", b_valid, 1'b0);
    check_flag("r_valid", r_valid, 1'b0);
    for (int n = 0; n < N_PAIRS; n++)
    begin
      make_req(req);
      run_write(req, -1, 1'b0, req);
      run_read(req, -1);
    end
    do
      make_req(req);
    while (req.len == 8'd0);
    run_write(req, int'(take_bits(3)) % int'(req.len), 1'b0, req);
    make_req(req);
    run_read(req, int'(take_bits(3)) % (int'(req.len) + 1));
    // both requests arrive at once and the read targets the words just written.
    make_req(req);
    make_req(req2);
    req2.addr  = req.addr;
    req2.len   = req.len;
    req2.burst = req.burst;
    run_write(req, -1, 1'b1, req2);
    run_read(req2, -1);
    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

// File: axi2ahb.f
logic/axi2ahb_pkg.sv
logic/bridge_ctrl.sv
logic/ahb_request.sv
logic/data_buffer.sv
logic/axi2ahb.sv
test/tb_clock.sv
test/axi2ahb_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module axi2ahb_tb -f axi2ahb.f -o sim_axi2ahb \
  && ./obj_dir/sim_axi2ahb || exit 1
